//--- hdl/rv_pkg.sv
package rv_pkg;

  // machine word and register index widths
  localparam int xlen      = 32;
  localparam int reg_idx_w = 5;
  localparam int num_regs  = 32;

  // opcodes kept by this core
  localparam logic [6:0] opc_lui     = 7'b0110111;
  localparam logic [6:0] opc_reg_imm = 7'b0010011;
  localparam logic [6:0] opc_reg_reg = 7'b0110011;
  localparam logic [6:0] opc_branch  = 7'b1100011;
  localparam logic [6:0] opc_system  = 7'b1110011;

  // alu funct3
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // branch funct3
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // selects sub and sra / srai
  localparam logic [6:0] f7_alt = 7'b0100000;

  localparam logic [xlen-1:0] insn_ecall = 32'h0000_0073;

  typedef struct packed {
    logic [6:0]           funct7;
    logic [reg_idx_w-1:0] rs2;
    logic [reg_idx_w-1:0] rs1;
    logic [2:0]           funct3;
    logic [reg_idx_w-1:0] rd;
    logic [6:0]           opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [19:0]          imm_hi;
    logic [reg_idx_w-1:0] rd;
    logic [6:0]           opcode;
  } u_fmt_t;

  // one instruction word, two views of its fields
  typedef union packed {
    r_fmt_t r;
    u_fmt_t u;
  } insn_t;

endpackage

//--- hdl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
  parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [rv_pkg::xlen-1:0] insn_from_imem,
  input  logic                    branch_taken,
  input  logic [rv_pkg::xlen-1:0] branch_target,
  output logic [rv_pkg::xlen-1:0] pc_to_imem,
  output logic [rv_pkg::xlen-1:0] d_pc,
  output rv_pkg::insn_t           d_insn
);
  import rv_pkg::*;

  logic [xlen-1:0] pc;

  assign pc_to_imem = pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc     <= reset_pc;
      d_pc   <= '0;
      d_insn <= '0;
    end else if (branch_taken) begin
      // redirect, and drop the word fetched on the wrong path
      pc     <= branch_target;
      d_pc   <= '0;
      d_insn <= '0;
    end else begin
      pc     <= pc + xlen'(4);
      d_pc   <= pc;
      d_insn <= insn_from_imem;
    end
  end

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [rv_pkg::reg_idx_w-1:0] rs1,
  input  logic [rv_pkg::reg_idx_w-1:0] rs2,
  input  logic                         we,
  input  logic [rv_pkg::reg_idx_w-1:0] rd,
  input  logic [rv_pkg::xlen-1:0]      rd_data,
  output logic [rv_pkg::xlen-1:0]      rs1_data,
  output logic [rv_pkg::xlen-1:0]      rs2_data
);
  import rv_pkg::*;

  // x0 has no storage
  logic [xlen-1:0] regs [1:num_regs-1];
  logic            wr_live;

  assign wr_live = we && (rd != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[rd] <= rd_data;
    end
  end

  // write-through gives decode the writeback value in the same cycle
  assign rs1_data = (rs1 == '0) ? '0 : (wr_live && rd == rs1) ? rd_data : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : (wr_live && rd == rs2) ? rd_data : regs[rs2];

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [rv_pkg::xlen-1:0]      d_pc,
  input  rv_pkg::insn_t                d_insn,
  input  logic                         branch_taken,
  input  logic                         w_we,
  input  logic [rv_pkg::reg_idx_w-1:0] w_rd,
  input  logic [rv_pkg::xlen-1:0]      w_data,
  output logic [rv_pkg::xlen-1:0]      x_pc,
  output rv_pkg::insn_t                x_insn,
  output logic [rv_pkg::xlen-1:0]      x_op1,
  output logic [rv_pkg::xlen-1:0]      x_op2,
  output logic [rv_pkg::xlen-1:0]      x_imm,
  output logic                         x_writes
);
  import rv_pkg::*;

  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_sh;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm;
  logic            writes;

  reg_file u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1      (d_insn.r.rs1),
    .rs2      (d_insn.r.rs2),
    .we       (w_we),
    .rd       (w_rd),
    .rd_data  (w_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // immediate formats built from the two views of the word
  assign imm_i  = {{(xlen-12){d_insn.r.funct7[6]}}, d_insn.r.funct7, d_insn.r.rs2};
  assign imm_sh = {{(xlen-reg_idx_w){1'b0}}, d_insn.r.rs2};
  assign imm_b  = {{(xlen-12){d_insn.r.funct7[6]}}, d_insn.r.rd[0],
                   d_insn.r.funct7[5:0], d_insn.r.rd[4:1], 1'b0};
  assign imm_u  = {d_insn.u.imm_hi, 12'b0};

  always_comb begin
    case (d_insn.r.opcode)
      opc_lui:     imm = imm_u;
      opc_reg_imm: begin
        // shift amounts are unsigned
        if (d_insn.r.funct3 == f3_sll || d_insn.r.funct3 == f3_sr) begin
          imm = imm_sh;
        end else begin
          imm = imm_i;
        end
      end
      opc_branch:  imm = imm_b;
      default:     imm = '0;
    endcase
  end

  assign writes = (d_insn.r.opcode == opc_lui || d_insn.r.opcode == opc_reg_imm ||
                   d_insn.r.opcode == opc_reg_reg) && (d_insn.r.rd != '0);

  always_ff @(posedge clk) begin
    if (rst || branch_taken) begin
      x_pc     <= '0;
      x_insn   <= '0;
      x_writes <= 1'b0;
    end else begin
      x_pc     <= d_pc;
      x_insn   <= d_insn;
      x_writes <= writes;
    end
  end

  always_ff @(posedge clk) begin
    x_op1 <= rs1_data;
    x_op2 <= rs2_data;
    x_imm <= imm;
  end

endmodule

//--- hdl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [rv_pkg::xlen-1:0]      x_pc,
  input  rv_pkg::insn_t                x_insn,
  input  logic [rv_pkg::xlen-1:0]      x_op1,
  input  logic [rv_pkg::xlen-1:0]      x_op2,
  input  logic [rv_pkg::xlen-1:0]      x_imm,
  input  logic                         x_writes,
  input  logic [rv_pkg::reg_idx_w-1:0] m_rd,
  input  logic                         m_writes,
  input  logic [rv_pkg::xlen-1:0]      m_result,
  input  logic [rv_pkg::reg_idx_w-1:0] w_rd,
  input  logic                         w_writes,
  input  logic [rv_pkg::xlen-1:0]      w_data,
  output logic                         branch_taken,
  output logic [rv_pkg::xlen-1:0]      branch_target,
  output logic [rv_pkg::xlen-1:0]      m_pc,
  output rv_pkg::insn_t                m_insn,
  output logic [rv_pkg::xlen-1:0]      m_result_out,
  output logic                         m_writes_out
);
  import rv_pkg::*;

  localparam int shamt_w = $clog2(xlen);

  logic [xlen-1:0]    op1;
  logic [xlen-1:0]    op2;
  logic [xlen-1:0]    alu_b;
  logic [xlen-1:0]    alu_out;
  logic [xlen-1:0]    result;
  logic [shamt_w-1:0] shamt;
  logic               sub_sel;
  logic               alt_sel;
  logic               cond;

  // write flags are only set for a nonzero rd, so x0 never bypasses
  // memory stage is the younger producer and wins
  always_comb begin
    op1 = x_op1;
    if (m_writes && m_rd == x_insn.r.rs1) begin
      op1 = m_result;
    end else if (w_writes && w_rd == x_insn.r.rs1) begin
      op1 = w_data;
    end
    op2 = x_op2;
    if (m_writes && m_rd == x_insn.r.rs2) begin
      op2 = m_result;
    end else if (w_writes && w_rd == x_insn.r.rs2) begin
      op2 = w_data;
    end
  end

  // register-immediate ops share the ALU with the immediate as second operand
  assign alu_b   = (x_insn.r.opcode == opc_reg_reg) ? op2 : x_imm;
  assign shamt   = alu_b[shamt_w-1:0];
  assign alt_sel = (x_insn.r.funct7 == f7_alt);
  assign sub_sel = alt_sel && (x_insn.r.opcode == opc_reg_reg);

  always_comb begin
    case (x_insn.r.funct3)
      f3_add:  alu_out = sub_sel ? op1 - alu_b : op1 + alu_b;
      f3_sll:  alu_out = op1 << shamt;
      f3_slt:  alu_out = xlen'($signed(op1) < $signed(alu_b));
      f3_sltu: alu_out = xlen'(op1 < alu_b);
      f3_xor:  alu_out = op1 ^ alu_b;
      f3_sr: begin
        if (alt_sel) begin
          alu_out = $signed(op1) >>> shamt;
        end else begin
          alu_out = op1 >> shamt;
        end
      end
      f3_or:   alu_out = op1 | alu_b;
      default: alu_out = op1 & alu_b;
    endcase
  end

  always_comb begin
    case (x_insn.r.opcode)
      opc_lui:     result = x_imm;
      opc_reg_imm: result = alu_out;
      opc_reg_reg: result = alu_out;
      default:     result = '0;
    endcase
  end

  // unsigned branch compares use the raw words
  always_comb begin
    case (x_insn.r.funct3)
      f3_beq:  cond = (op1 == op2);
      f3_bne:  cond = (op1 != op2);
      f3_blt:  cond = ($signed(op1) < $signed(op2));
      f3_bge:  cond = ($signed(op1) >= $signed(op2));
      f3_bltu: cond = (op1 < op2);
      f3_bgeu: cond = (op1 >= op2);
      default: cond = 1'b0;
    endcase
  end

  assign branch_taken  = (x_insn.r.opcode == opc_branch) && cond;
  assign branch_target = x_pc + x_imm;

  always_ff @(posedge clk) begin
    if (rst) begin
      m_pc         <= '0;
      m_insn       <= '0;
      m_writes_out <= 1'b0;
    end else begin
      m_pc         <= x_pc;
      m_insn       <= x_insn;
      m_writes_out <= x_writes;
    end
  end

  always_ff @(posedge clk) begin
    m_result_out <= result;
  end

endmodule

//--- hdl/retire_stages.sv
`timescale 1ns/1ps

module retire_stages (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [rv_pkg::xlen-1:0]      m_pc,
  input  rv_pkg::insn_t                m_insn,
  input  logic [rv_pkg::xlen-1:0]      m_result,
  input  logic                         m_writes,
  output logic [rv_pkg::reg_idx_w-1:0] m_rd,
  output logic                         w_we,
  output logic [rv_pkg::reg_idx_w-1:0] w_rd,
  output logic [rv_pkg::xlen-1:0]      w_data,
  output logic                         halt,
  output logic [rv_pkg::xlen-1:0]      trace_pc,
  output rv_pkg::insn_t                trace_insn
);
  import rv_pkg::*;

  logic [xlen-1:0] w_pc;
  insn_t           w_insn;
  logic            w_writes;

  // memory stage passes the result straight on, only rd is needed for bypass
  assign m_rd = m_insn.r.rd;

  always_ff @(posedge clk) begin
    if (rst) begin
      w_pc     <= '0;
      w_insn   <= '0;
      w_writes <= 1'b0;
    end else begin
      w_pc     <= m_pc;
      w_insn   <= m_insn;
      w_writes <= m_writes;
    end
  end

  always_ff @(posedge clk) begin
    w_data <= m_result;
  end

  assign w_we       = w_writes;
  assign w_rd       = w_insn.r.rd;
  assign halt       = (w_insn == insn_ecall);
  assign trace_pc   = w_pc;
  assign trace_insn = w_insn;

endmodule

//--- hdl/rv_pipeline.sv
`timescale 1ns/1ps

module rv_pipeline #(
  parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [rv_pkg::xlen-1:0]      insn_from_imem,
  output logic [rv_pkg::xlen-1:0]      pc_to_imem,
  output logic                         halt,
  output logic [rv_pkg::xlen-1:0]      trace_pc,
  output rv_pkg::insn_t                trace_insn,
  output logic                         wb_we,
  output logic [rv_pkg::reg_idx_w-1:0] wb_rd,
  output logic [rv_pkg::xlen-1:0]      wb_data
);
  import rv_pkg::*;

  // fetch to decode
  logic [xlen-1:0]      d_pc;
  insn_t                d_insn;
  // decode to execute
  logic [xlen-1:0]      x_pc;
  insn_t                x_insn;
  logic [xlen-1:0]      x_op1;
  logic [xlen-1:0]      x_op2;
  logic [xlen-1:0]      x_imm;
  logic                 x_writes;
  // execute to memory, and the redirect
  logic                 branch_taken;
  logic [xlen-1:0]      branch_target;
  logic [xlen-1:0]      m_pc;
  insn_t                m_insn;
  logic [xlen-1:0]      m_result;
  logic                 m_writes;
  logic [reg_idx_w-1:0] m_rd;

  fetch_stage #(.reset_pc(reset_pc)) u_fetch (
    .clk(clk), .rst(rst), .insn_from_imem(insn_from_imem),
    .branch_taken(branch_taken), .branch_target(branch_target),
    .pc_to_imem(pc_to_imem), .d_pc(d_pc), .d_insn(d_insn)
  );

  decode_stage u_decode (
    .clk(clk), .rst(rst), .d_pc(d_pc), .d_insn(d_insn), .branch_taken(branch_taken),
    .w_we(wb_we), .w_rd(wb_rd), .w_data(wb_data),
    .x_pc(x_pc), .x_insn(x_insn), .x_op1(x_op1), .x_op2(x_op2), .x_imm(x_imm),
    .x_writes(x_writes)
  );

  execute_stage u_execute (
    .clk(clk), .rst(rst), .x_pc(x_pc), .x_insn(x_insn), .x_op1(x_op1), .x_op2(x_op2),
    .x_imm(x_imm), .x_writes(x_writes),
    .m_rd(m_rd), .m_writes(m_writes), .m_result(m_result),
    .w_rd(wb_rd), .w_writes(wb_we), .w_data(wb_data),
    .branch_taken(branch_taken), .branch_target(branch_target),
    .m_pc(m_pc), .m_insn(m_insn), .m_result_out(m_result), .m_writes_out(m_writes)
  );

  retire_stages u_retire (
    .clk(clk), .rst(rst), .m_pc(m_pc), .m_insn(m_insn), .m_result(m_result),
    .m_writes(m_writes), .m_rd(m_rd), .w_we(wb_we), .w_rd(wb_rd), .w_data(wb_data),
    .halt(halt), .trace_pc(trace_pc), .trace_insn(trace_insn)
  );

endmodule

//--- dv/tb_rv_pipeline.sv
`timescale 1ns/1ps

module tb_rv_pipeline;
  import rv_pkg::*;

  localparam logic [xlen-1:0] reset_pc = 32'h0000_0100;
  localparam int imem_words = 256;
  localparam int run_limit = 400;

  logic                 clk;
  logic                 rst;
  logic [xlen-1:0]      insn_from_imem;
  logic [xlen-1:0]      pc_to_imem;
  logic                 halt;
  logic [xlen-1:0]      trace_pc;
  insn_t                trace_insn;
  logic                 wb_we;
  logic [reg_idx_w-1:0] wb_rd;
  logic [xlen-1:0]      wb_data;

  logic [xlen-1:0]      imem [imem_words];
  logic [7:0]           prog_idx;
  logic [xlen-1:0]      exp_pc [$];
  logic [xlen-1:0]      exp_insn [$];
  logic [reg_idx_w-1:0] exp_rd [$];
  logic [xlen-1:0]      exp_data [$];
  int                   tests;
  int                   checks;
  int                   errors;

  rv_pipeline #(.reset_pc(reset_pc)) dut (
    .clk            (clk),
    .rst            (rst),
    .insn_from_imem (insn_from_imem),
    .pc_to_imem     (pc_to_imem),
    .halt           (halt),
    .trace_pc       (trace_pc),
    .trace_insn     (trace_insn),
    .wb_we          (wb_we),
    .wb_rd          (wb_rd),
    .wb_data        (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // instruction memory answers the current pc on each falling edge
  initial begin
    insn_from_imem = '0;
    forever begin
      @(negedge clk);
      insn_from_imem <= imem[pc_to_imem[9:2]];
    end
  end

  task automatic check_word(input string name, input logic [xlen-1:0] got,
                            input logic [xlen-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_idx(input string name, input logic [reg_idx_w-1:0] got,
                           input logic [reg_idx_w-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_insn(input string name, input insn_t got, input insn_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // instruction encoders, straight from the ISA formats
  function automatic logic [xlen-1:0] r_type(input logic [6:0] f7,
      input logic [reg_idx_w-1:0] rs2, input logic [reg_idx_w-1:0] rs1,
      input logic [2:0] f3, input logic [reg_idx_w-1:0] rd);
    return {f7, rs2, rs1, f3, rd, opc_reg_reg};
  endfunction

  function automatic logic [xlen-1:0] i_type(input logic [11:0] imm,
      input logic [reg_idx_w-1:0] rs1, input logic [2:0] f3, input logic [reg_idx_w-1:0] rd);
    return {imm, rs1, f3, rd, opc_reg_imm};
  endfunction

  function automatic logic [xlen-1:0] shift_imm(input logic [2:0] f3, input logic alt,
      input logic [4:0] shamt, input logic [reg_idx_w-1:0] rs1, input logic [reg_idx_w-1:0] rd);
    return i_type({alt ? f7_alt : 7'd0, shamt}, rs1, f3, rd);
  endfunction

  function automatic logic [xlen-1:0] u_type(input logic [19:0] imm,
      input logic [reg_idx_w-1:0] rd);
    return {imm, rd, opc_lui};
  endfunction

  function automatic logic [xlen-1:0] b_type(input logic [12:0] off,
      input logic [reg_idx_w-1:0] rs2, input logic [reg_idx_w-1:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc_branch};
  endfunction

  // two's complement order, from the sign bits first
  function automatic logic signed_less(input logic [xlen-1:0] a, input logic [xlen-1:0] b);
    return (a[xlen-1] != b[xlen-1]) ? a[xlen-1] : (a < b);
  endfunction

  function automatic logic [xlen-1:0] model_alu(input logic [2:0] f3, input logic alt,
      input logic [xlen-1:0] a, input logic [xlen-1:0] b);
    logic [2*xlen-1:0] ext;
    ext = {{xlen{a[xlen-1]}}, a} >> b[4:0];
    case (f3)
      f3_add:  return alt ? a - b : a + b;
      f3_sll:  return a << b[4:0];
      f3_slt:  return {31'b0, signed_less(a, b)};
      f3_sltu: return {31'b0, a < b};
      f3_xor:  return a ^ b;
      f3_sr:   return alt ? ext[xlen-1:0] : a >> b[4:0];
      f3_or:   return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic model_cond(input logic [2:0] f3, input logic [xlen-1:0] a,
      input logic [xlen-1:0] b);
    case (f3)
      f3_beq:  return a == b;
      f3_bne:  return a != b;
      f3_blt:  return signed_less(a, b);
      f3_bge:  return !signed_less(a, b);
      f3_bltu: return a < b;
      f3_bgeu: return !(a < b);
      default: return 1'b0;
    endcase
  endfunction

  // unused words are addi x0 with the byte address as immediate
  task automatic clear_program();
    for (int i = 0; i < imem_words; i++) begin
      imem[8'(i)] = i_type({2'b00, 8'(i), 2'b00}, 5'd0, f3_add, 5'd0);
    end
    prog_idx = reset_pc[9:2];
  endtask

  task automatic emit(input logic [xlen-1:0] w);
    imem[prog_idx] = w;
    prog_idx = prog_idx + 8'd1;
  endtask

  // walks the program in order and queues what should retire and write
  task automatic model_run();
    logic [xlen-1:0] regs [num_regs];
    logic [xlen-1:0] pc;
    logic [xlen-1:0] w;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] res;
    logic [xlen-1:0] b_off;
    logic            wr;
    int              steps;
    exp_pc.delete();
    exp_insn.delete();
    exp_rd.delete();
    exp_data.delete();
    regs = '{default: '0};
    pc = reset_pc;
    w = '0;
    steps = 0;
    while (w != insn_ecall && steps < 200) begin
      w = imem[pc[9:2]];
      exp_pc.push_back(pc);
      exp_insn.push_back(w);
      a = regs[w[19:15]];
      b = regs[w[24:20]];
      b_off = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      wr = 1'b1;
      res = '0;
      case (w[6:0])
        opc_lui:     res = {w[31:12], 12'b0};
        opc_reg_imm: res = model_alu(w[14:12], w[30] && w[14:12] == f3_sr, a,
                                     {{20{w[31]}}, w[31:20]});
        opc_reg_reg: res = model_alu(w[14:12], w[30], a, b);
        default:     wr = 1'b0;
      endcase
      if (w[6:0] == opc_branch && model_cond(w[14:12], a, b)) begin
        pc = pc + b_off;
      end else begin
        pc = pc + 32'd4;
      end
      if (wr && w[11:7] != 5'd0) begin
        regs[w[11:7]] = res;
        exp_rd.push_back(w[11:7]);
        exp_data.push_back(res);
      end
      steps++;
    end
    if (w != insn_ecall) begin
      errors++;
      $display("reference model ran off the program without reaching ecall");
    end
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (8) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests++;
    $display("test %s %s", name, (errors == errs_before) ? "passed" : "failed");
  endtask

  task automatic check_retire();
    if (exp_pc.size() == 0) begin
      errors++;
      $display("unexpected instruction retired at pc %h", trace_pc);
    end else begin
      check_word("trace_pc", trace_pc, exp_pc.pop_front());
      check_insn("trace_insn", trace_insn, exp_insn.pop_front());
    end
  endtask

  task automatic check_write();
    if (exp_rd.size() == 0) begin
      errors++;
      $display("unexpected register write to x%0d at pc %h", wb_rd, trace_pc);
    end else begin
      check_idx("wb_rd", wb_rd, exp_rd.pop_front());
      check_word("wb_data", wb_data, exp_data.pop_front());
    end
  endtask

  // resets the DUT and follows retirement until the ecall halts it
  task automatic run_program(input string name);
    int   errs_before;
    int   cycles;
    logic done;
    errs_before = errors;
    model_run();
    apply_reset();
    done = 1'b0;
    cycles = 0;
    while (!done && cycles < run_limit) begin
      @(negedge clk);
      cycles++;
      if (trace_insn != '0) begin
        check_retire();
      end
      if (wb_we) begin
        check_write();
      end
      if (halt) begin
        check_insn("trace_insn", trace_insn, insn_ecall);
        check_word("wb_we", xlen'(wb_we), '0);
        done = 1'b1;
      end
    end
    if (!done) begin
      errors++;
      $display("halt not seen within %0d cycles", run_limit);
    end
    if (exp_pc.size() != 0 || exp_rd.size() != 0) begin
      errors++;
      $display("%0d retirements and %0d writes never happened", exp_pc.size(), exp_rd.size());
    end
    report_test(name, errs_before);
  endtask

  task automatic reset_values();
    int errs_before;
    errs_before = errors;
    clear_program();
    emit(insn_ecall);
    apply_reset();
    check_word("pc_to_imem", pc_to_imem, reset_pc);
    check_word("halt", xlen'(halt), '0);
    check_word("wb_we", xlen'(wb_we), '0);
    check_word("trace_pc", trace_pc, '0);
    check_insn("trace_insn", trace_insn, '0);
    report_test("reset_values", errs_before);
  endtask

  task automatic reg_imm_ops();
    clear_program();
    emit(i_type(12'($urandom), 5'd0, f3_add, 5'd1));
    emit(u_type({1'b1, 19'($urandom)}, 5'd3));
    emit(i_type(12'($urandom), 5'd0, f3_xor, 5'd2));
    emit(i_type(12'($urandom), 5'd3, f3_or, 5'd4));
    emit(i_type(12'($urandom), 5'd1, f3_and, 5'd5));
    // all-ones immediate only sits above x1 when compared unsigned
    emit(i_type(12'hfff, 5'd1, f3_sltu, 5'd6));
    emit(i_type(12'h800, 5'd3, f3_slt, 5'd7));
    emit(i_type(12'($urandom), 5'd3, f3_sltu, 5'd8));
    emit(shift_imm(f3_sll, 1'b0, 5'($urandom), 5'd3, 5'd9));
    emit(shift_imm(f3_sr, 1'b0, 5'($urandom), 5'd3, 5'd10));
    emit(shift_imm(f3_sr, 1'b1, 5'($urandom), 5'd3, 5'd11));
    emit(i_type(12'($urandom), 5'd2, f3_add, 5'd12));
    emit(insn_ecall);
    run_program("reg_imm_ops");
  endtask

  task automatic bypass_chains();
    logic [reg_idx_w-1:0] rd;
    logic [reg_idx_w-1:0] rs2;
    logic [reg_idx_w-1:0] prev;
    int                   op;
    clear_program();
    for (int r = 1; r < 8; r++) begin
      emit(u_type(20'($urandom), 5'(r)));
      emit(i_type(12'($urandom), 5'(r), f3_add, 5'(r)));
    end
    // ops 8 and 9 are sub and sra
    prev = 5'd1;
    for (int k = 0; k < 30; k++) begin
      op = k % 10;
      rd = 5'(1 + ($urandom % 7));
      rs2 = 5'(1 + ($urandom % 7));
      emit(r_type(op >= 8 ? f7_alt : 7'd0, rs2, prev, op == 9 ? f3_sr : 3'(op), rd));
      prev = rd;
    end
    // consumer three behind reads through the register file
    emit(r_type(7'd0, 5'd2, 5'd1, f3_add, 5'd8));
    emit(i_type(12'd0, 5'd0, f3_add, 5'd0));
    emit(i_type(12'd0, 5'd0, f3_add, 5'd0));
    emit(r_type(7'd0, 5'd3, 5'd8, f3_xor, 5'd9));
    emit(i_type(12'd0, 5'd0, f3_add, 5'd0));
    emit(r_type(7'd0, 5'd1, 5'd9, f3_sltu, 5'd10));
    emit(insn_ecall);
    run_program("bypass_chains");
  endtask

  task automatic branch_outcomes();
    logic [2:0]           f3;
    logic [reg_idx_w-1:0] rs1;
    logic [reg_idx_w-1:0] rs2;
    clear_program();
    // x1 negative, x2 positive, so every compare goes both ways
    emit(u_type({1'b1, 19'($urandom)}, 5'd1));
    emit(u_type({1'b0, 19'($urandom)}, 5'd2));
    for (int k = 0; k < 6; k++) begin
      f3 = 3'(k < 2 ? k : k + 2);
      for (int p = 0; p < 3; p++) begin
        rs1 = (p == 1) ? 5'd2 : 5'd1;
        rs2 = (p == 0) ? 5'd2 : 5'd1;
        emit(b_type(13'd12, rs2, rs1, f3));
        emit(i_type(12'd1, 5'd20, f3_add, 5'd20));
        emit(i_type(12'd2, 5'd21, f3_add, 5'd21));
        emit(i_type(12'd1, 5'd22, f3_add, 5'd22));
      end
    end
    emit(insn_ecall);
    run_program("branch_outcomes");
  endtask

  task automatic x0_writes();
    clear_program();
    emit(i_type(12'd5, 5'd0, f3_add, 5'd1));
    emit(i_type(12'($urandom), 5'd1, f3_add, 5'd0));
    emit(r_type(7'd0, 5'd1, 5'd1, f3_add, 5'd0));
    emit(r_type(7'd0, 5'd0, 5'd0, f3_or, 5'd2));
    emit(u_type(20'($urandom), 5'd0));
    emit(r_type(7'd0, 5'd0, 5'd1, f3_add, 5'd3));
    emit(i_type(12'd0, 5'd0, f3_add, 5'd0));
    emit(i_type(12'd0, 5'd0, f3_add, 5'd0));
    emit(r_type(7'd0, 5'd0, 5'd0, f3_xor, 5'd4));
    emit(insn_ecall);
    run_program("x0_writes");
  endtask

  task automatic ecall_halt();
    clear_program();
    emit(i_type(12'($urandom), 5'd0, f3_add, 5'd1));
    emit(insn_ecall);
    // never reaches writeback before halt
    emit(i_type(12'd7, 5'd0, f3_add, 5'd2));
    emit(i_type(12'd9, 5'd0, f3_add, 5'd3));
    run_program("ecall_halt");
  endtask

  initial begin
    void'($urandom(32'h1028_af87));
    rst = 1'b1;
    tests = 0;
    checks = 0;
    errors = 0;
    reset_values();
    reg_imm_ops();
    bypass_chains();
    branch_outcomes();
    x0_writes();
    ecall_halt();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- tb.f
hdl/rv_pkg.sv
hdl/fetch_stage.sv
hdl/reg_file.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/retire_stages.sv
hdl/rv_pipeline.sv
dv/tb_rv_pipeline.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module tb_rv_pipeline -f tb.f --Mdir obj_dir -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"
